/* Makefile */
# Verilator build and run of the fetch stage testbench

SIM := obj_dir/Vtb_if_stage

.PHONY: all run clean

all: run

$(SIM): list.f $(wildcard hdl/*.sv) $(wildcard tests/*.sv)
	verilator --binary --timing --assert --top-module tb_if_stage \
		-f list.f -o Vtb_if_stage

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" sim.log; then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* hdl/fetch_fifo.sv */
//////////////////////////////////////////////////
// prefetch FIFO between the bus master and decode
// holds address, word and bus error of each fetch
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module fetch_fifo #(
  parameter int unsigned FifoDepth = 3
) (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  input  wire                  flush_i,
  input  wire                  push_i,
  input  wire if_pkg::addr_t   push_addr_i,
  input  wire if_pkg::instr_t  push_instr_i,
  input  wire                  push_err_i,
  input  wire                  pop_i,
  output logic                 space_o,
  output logic                 valid_o,
  output if_pkg::addr_t        addr_o,
  output if_pkg::instr_t       instr_o,
  output logic                 err_o
);

  localparam int unsigned PtrW = $clog2(FifoDepth);
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  if_pkg::addr_t   addr_mem  [FifoDepth];
  if_pkg::instr_t  instr_mem [FifoDepth];
  logic            err_mem   [FifoDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push_en;
  logic            pop_en;

  // pointers wrap at the depth, which need not be a power of two
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // a flush wins over both push and pop
  assign push_en = push_i & space_o & ~flush_i;
  assign pop_en  = pop_i & valid_o & ~flush_i;

  //////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_en) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // count moves only when exactly one side fires
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // entry storage
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      addr_mem[wr_ptr_q]  <= push_addr_i;
      instr_mem[wr_ptr_q] <= push_instr_i;
      err_mem[wr_ptr_q]   <= push_err_i;
    end
  end

  assign space_o = (count_q != CntW'(FifoDepth));
  assign valid_o = (count_q != '0);

  // head entry
  assign addr_o  = addr_mem[rd_ptr_q];
  assign instr_o = instr_mem[rd_ptr_q];
  assign err_o   = err_mem[rd_ptr_q];

  // requester only starts a transfer with a free slot
  no_push_full_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push_i && !flush_i) |-> space_o);

  // decode side only pops a valid head
  no_pop_empty_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> valid_o);

endmodule

`default_nettype wire

/* hdl/fetch_requester.sv */
//////////////////////////////////////////////////
// fetch producer: picks the next PC and reads words
// over a Wishbone classic master, one transfer in flight
// responses go into the prefetch FIFO as push beats
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module fetch_requester (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  wire                       req_i,
  input  wire                       pc_set_i,
  input  wire if_pkg::pc_sel_e      pc_mux_i,
  input  wire if_pkg::addr_t        boot_addr_i,
  input  wire if_pkg::addr_t        branch_target_i,
  input  wire if_pkg::addr_t        csr_mepc_i,
  input  wire if_pkg::addr_t        csr_mtvec_i,
  input  wire if_pkg::exc_pc_sel_e  exc_pc_mux_i,
  input  wire if_pkg::irq_cause_t   irq_cause_i,
  input  wire if_pkg::instr_t       wb_dat_i,
  input  wire                       wb_ack_i,
  input  wire                       wb_err_i,
  input  wire                       space_i,
  output logic                      wb_cyc_o,
  output logic                      wb_stb_o,
  output logic                      wb_we_o,
  output if_pkg::addr_t             wb_adr_o,
  output logic                      push_o,
  output if_pkg::addr_t             push_addr_o,
  output if_pkg::instr_t            push_instr_o,
  output logic                      push_err_o,
  output logic                      csr_mtvec_init_o,
  output logic                      busy_o
);

  typedef enum logic {
    idle,
    wait_ack
  } bus_state_e;

  bus_state_e    state_q, state_d;
  if_pkg::addr_t exc_pc;
  if_pkg::addr_t target_pc;
  if_pkg::addr_t next_addr;
  if_pkg::addr_t fetch_addr_q;
  if_pkg::addr_t wb_adr_q;
  logic          pc_valid_q;
  logic          discard_q;
  logic          resp;
  logic          start;

  //////////////////////////////////////////////////
  // PC selection
  //////////////////////////////////////////////////

  // trap target, interrupts land in a 4-byte slot per cause
  always_comb begin
    unique case (exc_pc_mux_i)
      if_pkg::exc_pc_irq: begin
        exc_pc = {csr_mtvec_i[31:if_pkg::VecAlignBits], 1'b0, irq_cause_i, 2'b00};
      end
      default: begin
        exc_pc = {csr_mtvec_i[31:if_pkg::VecAlignBits], {if_pkg::VecAlignBits{1'b0}}};
      end
    endcase
  end

  // redirect target
  always_comb begin
    unique case (pc_mux_i)
      if_pkg::pc_jump: target_pc = branch_target_i;
      if_pkg::pc_exc:  target_pc = exc_pc;
      if_pkg::pc_eret: target_pc = csr_mepc_i;
      default:         target_pc = {boot_addr_i[31:if_pkg::VecAlignBits], if_pkg::BootOffset};
    endcase
  end

  // mtvec gets its reset value on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_pkg::pc_boot);

  // a redirect in the same cycle goes straight onto the bus
  assign next_addr = pc_set_i ? target_pc : fetch_addr_q;

  //////////////////////////////////////////////////
  // bus FSM
  //////////////////////////////////////////////////

  assign resp = (state_q == wait_ack) & (wb_ack_i | wb_err_i);

  // nothing is fetched before the first redirect;
  // a redirect flushes the FIFO, so a slot is free at the next edge
  assign start = (state_q == idle) & req_i & (space_i | pc_set_i) & (pc_valid_q | pc_set_i);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      idle: begin
        if (start) begin
          state_d = wait_ack;
        end
      end
      wait_ack: begin
        // cyc drops for at least one edge after the response
        if (wb_ack_i | wb_err_i) begin
          state_d = idle;
        end
      end
      default: begin
        state_d = idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= idle;
      pc_valid_q <= 1'b0;
      discard_q  <= 1'b0;
    end else begin
      state_q    <= state_d;
      pc_valid_q <= pc_valid_q | pc_set_i;
      // transfer in flight went stale, drop its response
      if (resp) begin
        discard_q <= 1'b0;
      end else if ((state_q == wait_ack) && pc_set_i) begin
        discard_q <= 1'b1;
      end
    end
  end

  // fetch address advances only on a response that is kept
  always_ff @(posedge clk_i) begin
    if (pc_set_i) begin
      fetch_addr_q <= target_pc;
    end else if (push_o) begin
      fetch_addr_q <= wb_adr_q + if_pkg::InstrBytes;
    end
    if (start) begin
      wb_adr_q <= next_addr;
    end
  end

  assign wb_cyc_o = (state_q == wait_ack);
  assign wb_stb_o = (state_q == wait_ack);
  assign wb_we_o  = 1'b0;
  assign wb_adr_o = wb_adr_q;

  // response beat toward the FIFO
  assign push_o       = resp & ~discard_q & ~pc_set_i;
  assign push_addr_o  = wb_adr_q;
  assign push_instr_o = wb_dat_i;
  assign push_err_o   = wb_err_i;

  assign busy_o = (state_q == wait_ack);

  // redirect targets must keep the bus word aligned
  wb_adr_aligned_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_o |-> (wb_adr_o[1:0] == 2'b00));

  // slave answers with one of ack or err, never both
  wb_ack_err_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_ack_i && wb_err_i));

endmodule

`default_nettype wire

/* hdl/if_id_register.sv */
//////////////////////////////////////////////////
// IF-ID pipeline register toward decode
// pops the FIFO head when decode is ready and holds it
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module if_id_register (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  input  wire                  squash_i,
  input  wire                  id_in_ready_i,
  input  wire                  instr_valid_clear_i,
  input  wire                  valid_i,
  input  wire if_pkg::addr_t   addr_i,
  input  wire if_pkg::instr_t  instr_i,
  input  wire                  err_i,
  output logic                 pop_o,
  output logic                 instr_valid_id_o,
  output logic                 instr_new_id_o,
  output if_pkg::instr_t       instr_rdata_id_o,
  output if_pkg::addr_t        pc_id_o,
  output logic                 instr_fetch_err_o
);

  logic instr_valid_d;
  logic instr_valid_q;
  logic instr_new_q;

  // head moves into the register whenever decode can take it
  assign pop_o = valid_i & id_in_ready_i;

  //////////////////////////////////////////////////
  // valid and new flags
  //////////////////////////////////////////////////

  // a redirect squashes the word arriving with it;
  // an older valid stays until decode clears it
  assign instr_valid_d = (pop_o & ~squash_i) | (instr_valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_q <= 1'b0;
      instr_new_q   <= 1'b0;
    end else begin
      instr_valid_q <= instr_valid_d;
      // one cycle pulse per arrival
      instr_new_q   <= pop_o;
    end
  end

  assign instr_valid_id_o = instr_valid_q;
  assign instr_new_id_o   = instr_new_q;

  //////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////

  // frozen while decode stalls
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      instr_rdata_id_o  <= instr_i;
      pc_id_o           <= addr_i;
      instr_fetch_err_o <= err_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/if_pkg.sv */
//////////////////////////////////////////////////
// shared types and constants of the fetch stage
// referenced with if_pkg:: scoped names by the
// requester, the prefetch FIFO and the IF-ID register
//////////////////////////////////////////////////

`default_nettype none

package if_pkg;

  //////////////////////////////////////////////////
  // widths with a meaning
  //////////////////////////////////////////////////

  // byte address on the fetch bus
  typedef logic [31:0] addr_t;

  // one 32-bit instruction word
  typedef logic [31:0] instr_t;

  // interrupt cause, picks the vector slot
  typedef logic [4:0] irq_cause_t;

  //////////////////////////////////////////////////
  // selectors
  //////////////////////////////////////////////////

  // source of the next PC on a redirect
  typedef enum logic [1:0] {
    pc_boot = 2'd0,
    pc_jump = 2'd1,
    pc_exc  = 2'd2,
    pc_eret = 2'd3
  } pc_sel_e;

  // kind of trap target
  typedef enum logic {
    exc_pc_exc = 1'b0,
    exc_pc_irq = 1'b1
  } exc_pc_sel_e;

  // low byte of the first fetch after boot
  localparam logic [7:0] BootOffset = 8'h80;

  // boot address and mtvec are aligned to 256 bytes
  localparam int unsigned VecAlignBits = 8;

  // every instruction is a full word
  localparam addr_t InstrBytes = 32'd4;

endpackage

`default_nettype wire

/* hdl/if_stage_top.sv */
//////////////////////////////////////////////////
// instruction fetch stage top level
// requester -> prefetch FIFO -> IF-ID register
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module if_stage_top #(
  parameter int unsigned FifoDepth = 3
) (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  wire if_pkg::addr_t        boot_addr_i,
  input  wire                       req_i,
  // redirect
  input  wire                       pc_set_i,
  input  wire if_pkg::pc_sel_e      pc_mux_i,
  input  wire if_pkg::addr_t        branch_target_i,
  input  wire if_pkg::addr_t        csr_mepc_i,
  input  wire if_pkg::addr_t        csr_mtvec_i,
  input  wire if_pkg::exc_pc_sel_e  exc_pc_mux_i,
  input  wire if_pkg::irq_cause_t   irq_cause_i,
  // decode handshake
  input  wire                       id_in_ready_i,
  input  wire                       instr_valid_clear_i,
  // Wishbone classic master
  output logic                      wb_cyc_o,
  output logic                      wb_stb_o,
  output logic                      wb_we_o,
  output if_pkg::addr_t             wb_adr_o,
  input  wire if_pkg::instr_t       wb_dat_i,
  input  wire                       wb_ack_i,
  input  wire                       wb_err_i,
  // toward decode
  output logic                      instr_valid_id_o,
  output logic                      instr_new_id_o,
  output if_pkg::instr_t            instr_rdata_id_o,
  output if_pkg::addr_t             pc_id_o,
  output logic                      instr_fetch_err_o,
  // status
  output logic                      csr_mtvec_init_o,
  output logic                      if_busy_o
);

  // requester to FIFO
  logic           push;
  if_pkg::addr_t  push_addr;
  if_pkg::instr_t push_instr;
  logic           push_err;
  logic           space;
  // FIFO to IF-ID register
  logic           fifo_valid;
  if_pkg::addr_t  fifo_addr;
  if_pkg::instr_t fifo_instr;
  logic           fifo_err;
  logic           pop;

  fetch_requester i_requester (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_cause_i      (irq_cause_i),
    .wb_dat_i         (wb_dat_i),
    .wb_ack_i         (wb_ack_i),
    .wb_err_i         (wb_err_i),
    .space_i          (space),
    .wb_cyc_o         (wb_cyc_o),
    .wb_stb_o         (wb_stb_o),
    .wb_we_o          (wb_we_o),
    .wb_adr_o         (wb_adr_o),
    .push_o           (push),
    .push_addr_o      (push_addr),
    .push_instr_o     (push_instr),
    .push_err_o       (push_err),
    .csr_mtvec_init_o (csr_mtvec_init_o),
    .busy_o           (if_busy_o)
  );

  // a redirect also empties the prefetch buffer
  fetch_fifo #(
    .FifoDepth (FifoDepth)
  ) i_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (pc_set_i),
    .push_i       (push),
    .push_addr_i  (push_addr),
    .push_instr_i (push_instr),
    .push_err_i   (push_err),
    .pop_i        (pop),
    .space_o      (space),
    .valid_o      (fifo_valid),
    .addr_o       (fifo_addr),
    .instr_o      (fifo_instr),
    .err_o        (fifo_err)
  );

  if_id_register i_if_id (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .squash_i            (pc_set_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .valid_i             (fifo_valid),
    .addr_i              (fifo_addr),
    .instr_i             (fifo_instr),
    .err_i               (fifo_err),
    .pop_o               (pop),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .pc_id_o             (pc_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o)
  );

  // boot target and mtvec reset value both assume 256-byte alignment
  boot_addr_aligned_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    boot_addr_i[if_pkg::VecAlignBits-1:0] == '0);

endmodule

`default_nettype wire

/* list.f */
hdl/if_pkg.sv
hdl/fetch_requester.sv
hdl/fetch_fifo.sv
hdl/if_id_register.sv
hdl/if_stage_top.sv
tests/wb_mem_model.sv
tests/tb_if_stage.sv

/* tests/tb_if_stage.sv */
//////////////////////////////////////////////////
// testbench of the fetch stage top level
// drives redirects and decode handshake on the falling edge,
// concurrent assertions and a PC scoreboard do the checks
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_if_stage;

  localparam logic [31:0] DataKey   = 32'hA5A5_A5A5;
  localparam logic [31:0] ErrAddr   = 32'h0000_1094;
  localparam int          MaxCycles = 4000;

  logic                clk_i;
  logic                rst_ni;
  if_pkg::addr_t       boot_addr_i;
  logic                req_i;
  logic                pc_set_i;
  if_pkg::pc_sel_e     pc_mux_i;
  if_pkg::addr_t       branch_target_i;
  if_pkg::addr_t       csr_mepc_i;
  if_pkg::addr_t       csr_mtvec_i;
  if_pkg::exc_pc_sel_e exc_pc_mux_i;
  if_pkg::irq_cause_t  irq_cause_i;
  logic                id_in_ready_i;
  logic                instr_valid_clear_i;
  wire                 wb_cyc_o;
  wire                 wb_stb_o;
  wire                 wb_we_o;
  if_pkg::addr_t       wb_adr_o;
  if_pkg::instr_t      wb_dat_i;
  wire                 wb_ack_i;
  wire                 wb_err_i;
  wire                 instr_valid_id_o;
  wire                 instr_new_id_o;
  if_pkg::instr_t      instr_rdata_id_o;
  if_pkg::addr_t       pc_id_o;
  wire                 instr_fetch_err_o;
  wire                 csr_mtvec_init_o;
  wire                 if_busy_o;

  // scoreboard state
  if_pkg::addr_t exp_pc;
  if_pkg::addr_t set_target;
  logic          booted;
  logic          err_seen;
  int            arrivals;
  int            cycles;
  int            value_errs;
  int            other_errs;
  int            seed;
  int            rnd;

  if_stage_top #(
    .FifoDepth (3)
  ) i_dut (
    .clk_i, .rst_ni, .boot_addr_i, .req_i, .pc_set_i, .pc_mux_i, .branch_target_i,
    .csr_mepc_i, .csr_mtvec_i, .exc_pc_mux_i, .irq_cause_i, .id_in_ready_i,
    .instr_valid_clear_i, .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_dat_i,
    .wb_ack_i, .wb_err_i, .instr_valid_id_o, .instr_new_id_o, .instr_rdata_id_o,
    .pc_id_o, .instr_fetch_err_o, .csr_mtvec_init_o, .if_busy_o
  );

  wb_mem_model #(
    .ErrAddr (ErrAddr),
    .Seed    (61003)
  ) i_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cyc_i  (wb_cyc_o),
    .stb_i  (wb_stb_o),
    .we_i   (wb_we_o),
    .adr_i  (wb_adr_o),
    .dat_o  (wb_dat_i),
    .ack_o  (wb_ack_i),
    .err_o  (wb_err_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // expected redirect targets
  //////////////////////////////////////////////////

  // boot lands 0x80 into its 256-byte block, traps use the mtvec block
  function automatic if_pkg::addr_t expected_target(input if_pkg::pc_sel_e sel);
    if_pkg::addr_t base;
    base = csr_mtvec_i & 32'hFFFF_FF00;
    case (sel)
      if_pkg::pc_boot: return (boot_addr_i & 32'hFFFF_FF00) + 32'h0000_0080;
      if_pkg::pc_jump: return branch_target_i;
      if_pkg::pc_eret: return csr_mepc_i;
      default: begin
        if (exc_pc_mux_i == if_pkg::exc_pc_irq) begin
          return base + 32'(irq_cause_i) * 32'd4;
        end
        return base;
      end
    endcase
  endfunction

  // one-cycle redirect, decode stalls for that cycle
  task automatic redirect(input if_pkg::pc_sel_e sel);
    pc_mux_i      = sel;
    set_target    = expected_target(sel);
    pc_set_i      = 1'b1;
    id_in_ready_i = 1'b0;
    @(negedge clk_i);
    pc_set_i      = 1'b0;
    id_in_ready_i = 1'b1;
  endtask

  task automatic wait_arrivals(input int n);
    int goal;
    goal = arrivals + n;
    while (arrivals < goal) begin
      @(negedge clk_i);
    end
  endtask

  // next PC advances per arrival, a redirect overrides it
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exp_pc   <= '0;
      booted   <= 1'b0;
      err_seen <= 1'b0;
      arrivals <= 0;
    end else begin
      if (instr_new_id_o) begin
        exp_pc   <= exp_pc + 32'd4;
        arrivals <= arrivals + 1;
        if (instr_fetch_err_o) begin
          err_seen <= 1'b1;
        end
      end
      if (pc_set_i) begin
        exp_pc <= set_target;
        booted <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  pc_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> pc_id_o == exp_pc)
    else begin
      $display("error %0t pc_id_o got %h expected %h", $time, $sampled(pc_id_o),
               $sampled(exp_pc));
      value_errs++;
    end

  data_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_rdata_id_o == (exp_pc ^ DataKey))
    else begin
      $display("error %0t instr_rdata_id_o got %h expected %h", $time,
               $sampled(instr_rdata_id_o), $sampled(exp_pc) ^ DataKey);
      value_errs++;
    end

  fetch_err_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_fetch_err_o == (exp_pc == ErrAddr))
    else begin
      $display("error %0t instr_fetch_err_o got %b expected %b", $time,
               $sampled(instr_fetch_err_o), $sampled(exp_pc) == ErrAddr);
      value_errs++;
    end

  mtvec_init_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_mtvec_init_o == (pc_set_i && pc_mux_i == if_pkg::pc_boot))
    else begin
      $display("error %0t csr_mtvec_init_o got %b expected %b", $time,
               $sampled(csr_mtvec_init_o), $sampled(pc_set_i && pc_mux_i == if_pkg::pc_boot));
      value_errs++;
    end

  // busy while a bus transfer is open
  busy_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    if_busy_o == wb_cyc_o)
    else begin
      $display("error %0t if_busy_o got %b expected %b", $time,
               $sampled(if_busy_o), $sampled(wb_cyc_o));
      value_errs++;
    end

  // bus stays quiet until the first boot redirect
  no_fetch_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !booted |-> !wb_cyc_o)
    else begin
      $display("%0t bus cycle started before the boot redirect", $time);
      other_errs++;
    end

  // idle bus takes the new target on the next cycle
  idle_redirect_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pc_set_i && !wb_cyc_o) |=> wb_cyc_o && wb_adr_o == $past(set_target))
    else begin
      $display("%0t redirect on an idle bus did not start a fetch at the target", $time);
      other_errs++;
    end

  wb_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_stb_o && !wb_ack_i && !wb_err_i) |=> wb_cyc_o && wb_stb_o && $stable(wb_adr_o))
    else begin
      $display("%0t bus master dropped stb or moved the address before a response", $time);
      other_errs++;
    end

  wb_end_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_cyc_o && (wb_ack_i || wb_err_i)) |=> !wb_cyc_o && !wb_stb_o)
    else begin
      $display("%0t bus master kept cyc high after a response", $time);
      other_errs++;
    end

  wb_read_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !wb_we_o && (wb_cyc_o == wb_stb_o))
    else begin
      $display("%0t bus master wrote or split cyc from stb", $time);
      other_errs++;
    end

  // stalled decode sees a frozen instruction
  stall_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!id_in_ready_i && instr_valid_id_o) |=> !instr_new_id_o && $stable(pc_id_o)
      && $stable(instr_rdata_id_o) && $stable(instr_fetch_err_o))
    else begin
      $display("%0t decode outputs changed while decode was stalled", $time);
      other_errs++;
    end

  new_valid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_valid_id_o)
    else begin
      $display("error %0t instr_valid_id_o got 0 expected 1", $time);
      value_errs++;
    end

  valid_clear_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_valid_clear_i && !id_in_ready_i) |=> !instr_valid_id_o)
    else begin
      $display("error %0t instr_valid_id_o got 1 expected 0", $time);
      value_errs++;
    end

  // run limit
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("timeout, stimulus did not complete within %0d cycles", MaxCycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    seed                = 61003;
    cycles              = 0;
    value_errs          = 0;
    other_errs          = 0;
    set_target          = '0;
    rst_ni              = 1'b0;
    boot_addr_i         = 32'h0000_1000;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = if_pkg::pc_boot;
    branch_target_i     = '0;
    csr_mepc_i          = '0;
    csr_mtvec_i         = 32'h0000_30C1;
    exc_pc_mux_i        = if_pkg::exc_pc_exc;
    irq_cause_i         = '0;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    req_i  = 1'b1;
    // fetch enabled but no PC yet
    repeat (4) @(negedge clk_i);

    // boot and sequential run across the error address
    redirect(if_pkg::pc_boot);
    wait_arrivals(12);

    // jump on an idle or busy bus, then one that hits a transfer in flight
    branch_target_i = 32'h0000_2000;
    redirect(if_pkg::pc_jump);
    wait_arrivals(6);
    while (!wb_cyc_o) begin
      @(negedge clk_i);
    end
    branch_target_i = 32'h0000_2400;
    redirect(if_pkg::pc_jump);
    wait_arrivals(6);

    // trap vectors and return
    exc_pc_mux_i = if_pkg::exc_pc_exc;
    redirect(if_pkg::pc_exc);
    wait_arrivals(4);
    exc_pc_mux_i = if_pkg::exc_pc_irq;
    irq_cause_i  = 5'd5;
    redirect(if_pkg::pc_exc);
    wait_arrivals(4);
    csr_mepc_i = 32'h0000_5008;
    redirect(if_pkg::pc_eret);
    wait_arrivals(4);

    // decode back-pressure
    while (arrivals < 80) begin
      @(negedge clk_i);
      rnd           = $random(seed);
      id_in_ready_i = rnd[0];
    end

    // decode drops the held instruction without a pop
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b1;
    @(negedge clk_i);
    instr_valid_clear_i = 1'b0;
    repeat (3) @(negedge clk_i);
    id_in_ready_i = 1'b1;
    wait_arrivals(4);
    repeat (2) @(negedge clk_i);

    if (!err_seen) begin
      $display("the instruction at the bus error address never reached decode");
      other_errs++;
    end
    $display("%0d instructions checked, %0d value errors, %0d other errors",
             arrivals, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/wb_mem_model.sv */
//////////////////////////////////////////////////
// Wishbone classic slave for the fetch testbench
// read data is the address xor a fixed key, 0 to 3 wait states
// one address answers with err instead of ack
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module wb_mem_model #(
  parameter logic [31:0] ErrAddr = 32'h0000_1094,
  parameter int          Seed    = 61003
) (
  input  wire         clk_i,
  input  wire         rst_ni,
  input  wire         cyc_i,
  input  wire         stb_i,
  input  wire         we_i,
  input  wire  [31:0] adr_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic        err_o
);

  localparam logic [31:0] DataKey = 32'hA5A5_A5A5;

  int         seed;
  int         rnd;
  logic [1:0] wait_left;
  logic [1:0] cnt_q;
  logic       pending_q;

  initial begin
    seed = Seed;
  end

  // response is registered and lasts one cycle;
  // the master drops cyc right after it, so no second answer
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o     <= 1'b0;
      err_o     <= 1'b0;
      dat_o     <= '0;
      pending_q <= 1'b0;
      cnt_q     <= '0;
    end else begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
      if (cyc_i && stb_i && !we_i && !ack_o && !err_o) begin
        // fresh request draws its wait states
        if (pending_q) begin
          wait_left = cnt_q;
        end else begin
          rnd       = $random(seed);
          wait_left = rnd[1:0];
        end
        if (wait_left == 2'd0) begin
          pending_q <= 1'b0;
          dat_o     <= adr_i ^ DataKey;
          if (adr_i == ErrAddr) begin
            err_o <= 1'b1;
          end else begin
            ack_o <= 1'b1;
          end
        end else begin
          pending_q <= 1'b1;
          cnt_q     <= wait_left - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire
